//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_processor
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Test failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/processor_properties.sv
`timescale 1ns/100ps
// Assertions bound to the processor top level
// Strobes during reset, write register, PC hold on a stall and known strobes

module processor_properties (
    input logic                clock,
    input logic                arst_n,
    input logic                wren,
    input logic                ctrl_writeEnable,
    input proc_pkg::reg_addr_t ctrl_writeReg,
    input proc_pkg::word_t     address_imem,
    input logic                stall,
    input logic                redirect
);

    quiet_in_reset: assert property (@(posedge clock)
        !arst_n |-> (!wren && !ctrl_writeEnable))
        else $error("memory or register write strobe active during reset");

    write_reg_nonzero: assert property (@(posedge clock) disable iff (!arst_n)
        ctrl_writeEnable |-> (ctrl_writeReg != '0))
        else $error("register write enabled with r0 as destination");

    // PC holds for one cycle unless a redirect overrides the stall
    pc_held_on_stall: assert property (@(posedge clock) disable iff (!arst_n)
        (stall && !redirect) |=> $stable(address_imem))
        else $error("instruction address moved during a stall");

    strobes_known: assert property (@(posedge clock) disable iff (!arst_n)
        !$isunknown({wren, ctrl_writeEnable}))
        else $error("write strobe unknown after reset");

endmodule

bind processor processor_properties props_i (
    .clock            (clock),
    .arst_n           (arst_n),
    .wren             (wren),
    .ctrl_writeEnable (ctrl_writeEnable),
    .ctrl_writeReg    (ctrl_writeReg),
    .address_imem     (address_imem),
    .stall            (stall),
    .redirect         (redirect)
);

//--- bench/tb_processor.sv
`timescale 1ns/100ps
// Testbench for the five-stage pipelined processor
// Models the memories and register file, runs a fixed program and checks the
// register write and store streams against an instruction-level model

module tb_processor;
    import proc_pkg::*;

    localparam int          MEM_WORDS      = 64;
    localparam int          MODEL_STEPS    = 200;
    localparam int          TIMEOUT_CYCLES = 2000;
    localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

    logic      clock;
    logic      arst_n;
    word_t     address_imem;
    word_t     q_imem;
    word_t     address_dmem;
    word_t     data;
    logic      wren;
    word_t     q_dmem;
    logic      ctrl_writeEnable;
    reg_addr_t ctrl_writeReg;
    reg_addr_t ctrl_readRegA;
    reg_addr_t ctrl_readRegB;
    word_t     data_writeReg;
    word_t     data_readRegA;
    word_t     data_readRegB;

    word_t       rom [MEM_WORDS];
    word_t       ram [MEM_WORDS];
    word_t       regs [32];
    word_t       shadow_ram [MEM_WORDS];
    word_t       shadow_regs [32];
    logic [31:0] lfsr_state;

    // Expected register writes and stores, oldest first
    reg_addr_t exp_reg_q [$];
    word_t     exp_val_q [$];
    word_t     exp_addr_q [$];
    word_t     exp_data_q [$];

    int value_errors;
    int other_errors;

    processor processor_i (.*);

    // Combinational reads, register file written on the falling edge
    assign q_imem        = rom[address_imem[5:0]];
    assign q_dmem        = ram[address_dmem[5:0]];
    assign data_readRegA = regs[ctrl_readRegA];
    assign data_readRegB = regs[ctrl_readRegB];

    always @(negedge clock) begin
        if (ctrl_writeEnable && ctrl_writeReg != '0) begin
            regs[ctrl_writeReg] <= data_writeReg;
        end
    end

    always @(posedge clock) begin
        if (wren) begin
            ram[address_dmem[5:0]] <= data;
        end
    end

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic logic next_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return out;
    endfunction

    function automatic word_t random_word();
        word_t w;
        w = '0;
        for (int b = 0; b < 32; b++) begin
            w = {w[30:0], next_bit()};
        end
        return w;
    endfunction

    function automatic word_t rtype_instr(alu_op_t f, int rd, int rs, int rt, int sh);
        return {OP_RTYPE, 5'(rd), 5'(rs), 5'(rt), 5'(sh), f, 2'b00};
    endfunction

    function automatic word_t imm_instr(opcode_t op, int rd, int rs, int imm);
        return {op, 5'(rd), 5'(rs), 17'(imm)};
    endfunction

    function automatic word_t jump_instr(opcode_t op, int target);
        return {op, 27'(target)};
    endfunction

    task automatic load_program();
        // Unused words jump to themselves
        for (int i = 0; i < MEM_WORDS; i++) begin
            rom[i] = jump_instr(OP_J, i);
        end
        rom[0]  = imm_instr(OP_ADDI, 1, 0, 5);
        rom[1]  = imm_instr(OP_ADDI, 2, 1, -8);
        rom[2]  = rtype_instr(ALU_ADD, 3, 1, 2, 0);
        rom[3]  = rtype_instr(ALU_SUB, 4, 3, 1, 0);
        rom[4]  = rtype_instr(ALU_AND, 5, 4, 7, 0);
        rom[5]  = rtype_instr(ALU_OR, 6, 5, 3, 0);
        rom[6]  = rtype_instr(ALU_SLL, 8, 6, 0, 4);
        rom[7]  = rtype_instr(ALU_SRA, 9, 2, 0, 1);
        rom[8]  = imm_instr(OP_ADDI, 10, 0, 16);
        rom[9]  = imm_instr(OP_SW, 9, 10, 0);
        rom[10] = imm_instr(OP_LW, 11, 10, 0);
        rom[11] = rtype_instr(ALU_ADD, 12, 11, 1, 0);
        rom[12] = imm_instr(OP_LW, 13, 10, 1);
        rom[13] = imm_instr(OP_SW, 13, 10, 2);
        rom[14] = imm_instr(OP_BNE, 1, 2, 2);
        rom[15] = imm_instr(OP_ADDI, 14, 0, 111);
        rom[16] = imm_instr(OP_ADDI, 15, 0, 222);
        rom[17] = imm_instr(OP_BNE, 1, 1, 5);
        rom[18] = imm_instr(OP_BLT, 2, 1, 1);
        rom[19] = imm_instr(OP_ADDI, 16, 0, 333);
        rom[20] = imm_instr(OP_BLT, 1, 2, 3);
        rom[21] = imm_instr(OP_ADDI, 17, 0, 7);
        rom[22] = jump_instr(OP_JAL, 25);
        rom[23] = imm_instr(OP_ADDI, 18, 0, 1);
        rom[24] = imm_instr(OP_ADDI, 19, 0, 2);
        rom[25] = imm_instr(OP_ADDI, 20, 0, 29);
        rom[26] = imm_instr(OP_JR, 20, 0, 0);
        rom[27] = imm_instr(OP_ADDI, 21, 0, 3);
        rom[28] = imm_instr(OP_ADDI, 22, 0, 4);
        // Unknown opcode behaves as a no-op
        rom[29] = {5'd20, 27'h123_4567};
        rom[30] = rtype_instr(ALU_ADD, 23, 31, 17, 0);
        rom[31] = jump_instr(OP_J, 31);
    endtask

    function automatic void record_write(reg_addr_t r, word_t v);
        if (r != '0) begin
            shadow_regs[r] = v;
            exp_reg_q.push_back(r);
            exp_val_q.push_back(v);
        end
    endfunction

    function automatic void record_store(word_t addr, word_t v);
        shadow_ram[addr[5:0]] = v;
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(v);
    endfunction

    // Instruction-level model on the shadow register file and RAM
    function automatic void run_reference();
        word_t     pc;
        word_t     next_pc;
        word_t     instr;
        word_t     a;
        word_t     b;
        word_t     t;
        word_t     imm;
        word_t     addr;
        word_t     target;
        reg_addr_t rd;
        logic      done;
        int        steps;
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < MODEL_STEPS) begin
            instr   = rom[pc[5:0]];
            rd      = instr[26:22];
            a       = shadow_regs[instr[21:17]];
            b       = shadow_regs[rd];
            t       = shadow_regs[instr[16:12]];
            imm     = {{15{instr[16]}}, instr[16:0]};
            target  = {5'b0, instr[26:0]};
            addr    = a + imm;
            next_pc = pc + 1;
            case (instr[31:27])
                OP_RTYPE: begin
                    case (instr[6:2])
                        ALU_ADD: record_write(rd, a + t);
                        ALU_SUB: record_write(rd, a - t);
                        ALU_AND: record_write(rd, a & t);
                        ALU_OR:  record_write(rd, a | t);
                        ALU_SLL: record_write(rd, a << instr[11:7]);
                        ALU_SRA: record_write(rd, word_t'($signed(a) >>> instr[11:7]));
                        default: ;
                    endcase
                end
                OP_ADDI: record_write(rd, addr);
                OP_LW:   record_write(rd, shadow_ram[addr[5:0]]);
                OP_SW:   record_store(addr, b);
                OP_BNE: begin
                    if (b != a) begin
                        next_pc = pc + 1 + imm;
                    end
                end
                OP_BLT: begin
                    if ($signed(b) < $signed(a)) begin
                        next_pc = pc + 1 + imm;
                    end
                end
                OP_J: begin
                    done    = (target == pc);
                    next_pc = target;
                end
                OP_JAL: begin
                    record_write(5'd31, pc + 1);
                    next_pc = target;
                end
                OP_JR:   next_pc = b;
                default: ;
            endcase
            pc = next_pc;
            steps++;
        end
    endfunction

    task automatic check_value(string name, word_t got, word_t expected);
        if (got !== expected) begin
            $display("error %s: got %h, expected %h", name, got, expected);
            value_errors++;
        end
    endtask

    // Register writes are taken where the register file samples them
    always @(negedge clock) begin
        if (arst_n && ctrl_writeEnable) begin
            if (exp_reg_q.size() == 0) begin
                $display("Unexpected register write to r%0d", ctrl_writeReg);
                other_errors++;
            end else begin
                check_value("ctrl_writeReg", word_t'(ctrl_writeReg),
                            word_t'(exp_reg_q.pop_front()));
                check_value("data_writeReg", data_writeReg, exp_val_q.pop_front());
            end
        end
    end

    always @(posedge clock) begin
        if (arst_n && wren) begin
            if (exp_addr_q.size() == 0) begin
                $display("Unexpected store to address %h", address_dmem);
                other_errors++;
            end else begin
                check_value("address_dmem", address_dmem, exp_addr_q.pop_front());
                check_value("data", data, exp_data_q.pop_front());
            end
        end
    end

    initial begin
        int i;
        int cycles;
        value_errors = 0;
        other_errors = 0;
        arst_n       = 1'b0;
        lfsr_state   = 32'h55d8;
        load_program();
        for (i = 0; i < 32; i++) begin
            shadow_regs[i] = random_word();
        end
        shadow_regs[0] = '0;
        for (i = 0; i < MEM_WORDS; i++) begin
            shadow_ram[i] = random_word();
        end
        for (i = 0; i < 32; i++) begin
            regs[i] <= shadow_regs[i];
        end
        for (i = 0; i < MEM_WORDS; i++) begin
            ram[i] <= shadow_ram[i];
        end
        run_reference();

        for (i = 0; i < 16; i++) begin
            @(negedge clock);
            check_value("wren", word_t'(wren), '0);
            check_value("ctrl_writeEnable", word_t'(ctrl_writeEnable), '0);
            check_value("address_imem", address_imem, '0);
        end
        @(posedge clock);
        arst_n <= 1'b1;
        // First cycle out of reset
        @(negedge clock);
        check_value("wren", word_t'(wren), '0);
        check_value("ctrl_writeEnable", word_t'(ctrl_writeEnable), '0);
        check_value("address_imem", address_imem, '0);

        cycles = 0;
        while ((exp_reg_q.size() != 0 || exp_addr_q.size() != 0) &&
               cycles < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycles++;
        end
        if (exp_reg_q.size() != 0 || exp_addr_q.size() != 0) begin
            $display("Timeout with %0d register writes and %0d stores still expected",
                     exp_reg_q.size(), exp_addr_q.size());
            other_errors++;
        end
        // Extra cycles so that a stray write after the last one is seen
        for (cycles = 0; cycles < 20; cycles++) begin
            @(posedge clock);
        end

        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- sim.f
source/proc_pkg.sv
source/pipe_if.sv
source/alu.sv
source/fetch_unit.sv
source/decode_unit.sv
source/hazard_unit.sv
source/execute_unit.sv
source/mem_wb_unit.sv
source/processor.sv
bench/processor_properties.sv
bench/tb_processor.sv

//--- source/alu.sv
`timescale 1ns/100ps
// Integer ALU
// Add, subtract, logic and shifts, plus not-equal and signed less-than flags

module alu (
    input  proc_pkg::word_t   a,
    input  proc_pkg::word_t   b,
    input  proc_pkg::alu_op_t op,
    input  proc_pkg::shamt_t  shamt,
    output proc_pkg::word_t   result,
    output logic              not_equal,
    output logic              less_than
);
    import proc_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_SLL: result = a << shamt;
            ALU_SRA: result = word_t'($signed(a) >>> shamt);
            default: result = '0;
        endcase
    end

    // Branch flags
    assign not_equal = (a != b);
    assign less_than = ($signed(a) < $signed(b));

endmodule

//--- source/decode_unit.sv
`timescale 1ns/100ps
// Decode stage
// Splits the FD instruction into fields, reads the register file and loads DX

module decode_unit (
    input  logic                clock,
    input  logic                arst_n,
    input  proc_pkg::word_t     fd_instr,
    input  proc_pkg::word_t     fd_pc,
    input  logic                fd_valid,
    input  logic                stall,
    input  logic                redirect,
    output proc_pkg::reg_addr_t ctrl_readRegA,
    output proc_pkg::reg_addr_t ctrl_readRegB,
    input  proc_pkg::word_t     data_readRegA,
    input  proc_pkg::word_t     data_readRegB,
    output logic                uses_a,
    output logic                uses_b,
    dx_if.stage                 dx
);
    import proc_pkg::*;

    reg_addr_t rd;
    reg_addr_t rs;
    reg_addr_t rt;
    opcode_t   op;
    alu_op_t   alu_op;
    reg_addr_t dest;
    logic      bubble;

    assign rd = fd_instr[RD_HI:RD_LO];
    assign rs = fd_instr[RS_HI:RS_LO];
    assign rt = fd_instr[RT_HI:RT_LO];

    // Unsupported opcodes and ALU functions become a no-op
    always_comb begin
        op     = OP_NOP;
        alu_op = ALU_ADD;
        case (fd_instr[OPC_HI:OPC_LO])
            OP_RTYPE: begin
                case (fd_instr[ALUOP_HI:ALUOP_LO])
                    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLL, ALU_SRA: begin
                        op     = OP_RTYPE;
                        alu_op = alu_op_t'(fd_instr[ALUOP_HI:ALUOP_LO]);
                    end
                    default: op = OP_NOP;
                endcase
            end
            OP_J, OP_BNE, OP_JAL, OP_JR, OP_ADDI, OP_BLT, OP_SW, OP_LW: begin
                op = opcode_t'(fd_instr[OPC_HI:OPC_LO]);
            end
            default: op = OP_NOP;
        endcase
    end

    always_comb begin
        case (op)
            OP_RTYPE, OP_ADDI, OP_LW: dest = rd;
            OP_JAL:                   dest = LINK_REG;
            default:                  dest = '0;
        endcase
    end

    // Port B reads rt for R-type and rd otherwise
    assign ctrl_readRegA = rs;
    assign ctrl_readRegB = (op == OP_RTYPE) ? rt : rd;

    assign uses_a = fd_valid && (op inside {OP_RTYPE, OP_ADDI, OP_LW, OP_SW, OP_BNE, OP_BLT});
    assign uses_b = fd_valid && (op inside {OP_RTYPE, OP_SW, OP_BNE, OP_BLT, OP_JR});

    assign bubble = stall || redirect || !fd_valid;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            dx.valid <= 1'b0;
            dx.op    <= OP_NOP;
            dx.dest  <= '0;
        end else if (bubble) begin
            dx.valid <= 1'b0;
            dx.op    <= OP_NOP;
            dx.dest  <= '0;
        end else begin
            dx.valid <= 1'b1;
            dx.op    <= op;
            dx.dest  <= dest;
        end
    end

    always_ff @(posedge clock) begin
        dx.alu_op  <= alu_op;
        dx.shamt   <= fd_instr[SHAMT_HI:SHAMT_LO];
        dx.reg_a   <= ctrl_readRegA;
        dx.reg_b   <= ctrl_readRegB;
        dx.a_value <= data_readRegA;
        dx.b_value <= data_readRegB;
        dx.imm     <= {{(WORD_W-IMM_W){fd_instr[IMM_W-1]}}, fd_instr[IMM_W-1:0]};
        dx.target  <= {{(WORD_W-TARGET_W){1'b0}}, fd_instr[TARGET_W-1:0]};
        dx.pc      <= fd_pc;
    end

endmodule

//--- source/execute_unit.sv
`timescale 1ns/100ps
// Execute stage
// Forwards operands, runs the ALU and resolves branches and jumps

module execute_unit (
    dx_if.sink                  dx,
    result_if.sink              res,
    input  proc_pkg::fwd_sel_t  fwd_a,
    input  proc_pkg::fwd_sel_t  fwd_b,
    output logic                redirect,
    output proc_pkg::word_t     redirect_pc,
    output logic                ex_valid,
    output proc_pkg::opcode_t   ex_op,
    output proc_pkg::reg_addr_t ex_dest,
    output proc_pkg::word_t     ex_result,
    output proc_pkg::word_t     ex_store_data
);
    import proc_pkg::*;

    word_t   a_fwd;
    word_t   b_fwd;
    word_t   alu_a;
    word_t   alu_b;
    word_t   alu_result;
    word_t   pc_plus_one;
    alu_op_t op_sel;
    logic    not_equal;
    logic    less_than;
    logic    branch_taken;
    logic    jump;

    function automatic word_t forward(fwd_sel_t sel, word_t reg_value,
                                      word_t xm_value, word_t mw_value);
        word_t value;
        case (sel)
            FWD_XM:  value = xm_value;
            FWD_MW:  value = mw_value;
            default: value = reg_value;
        endcase
        return value;
    endfunction

    assign a_fwd = forward(fwd_a, dx.a_value, res.xm_result, res.mw_result);
    assign b_fwd = forward(fwd_b, dx.b_value, res.xm_result, res.mw_result);

    always_comb begin
        alu_a  = a_fwd;
        alu_b  = b_fwd;
        op_sel = ALU_ADD;
        case (dx.op)
            OP_RTYPE: op_sel = dx.alu_op;
            OP_ADDI, OP_LW, OP_SW: alu_b = dx.imm;
            OP_BNE, OP_BLT: begin
                // rd is compared against rs
                alu_a  = b_fwd;
                alu_b  = a_fwd;
                op_sel = ALU_SUB;
            end
            default: ;
        endcase
    end

    alu u_alu (
        .a         (alu_a),
        .b         (alu_b),
        .op        (op_sel),
        .shamt     (dx.shamt),
        .result    (alu_result),
        .not_equal (not_equal),
        .less_than (less_than)
    );

    assign pc_plus_one  = dx.pc + word_t'(1);
    assign branch_taken = dx.valid && ((dx.op == OP_BNE && not_equal) ||
                                       (dx.op == OP_BLT && less_than));
    assign jump         = dx.valid && (dx.op inside {OP_J, OP_JAL, OP_JR});
    assign redirect     = branch_taken || jump;

    always_comb begin
        case (dx.op)
            OP_J, OP_JAL: redirect_pc = dx.target;
            OP_JR:        redirect_pc = b_fwd;
            default:      redirect_pc = pc_plus_one + dx.imm;
        endcase
    end

    assign ex_valid      = dx.valid;
    assign ex_op         = dx.op;
    assign ex_dest       = dx.dest;
    assign ex_result     = (dx.op == OP_JAL) ? pc_plus_one : alu_result;
    assign ex_store_data = b_fwd;

endmodule

//--- source/fetch_unit.sv
`timescale 1ns/100ps
// Fetch stage
// Holds the PC, picks the next PC and fills the FD register

module fetch_unit (
    input  logic            clock,
    input  logic            arst_n,
    input  logic            stall,
    input  logic            redirect,
    input  proc_pkg::word_t redirect_pc,
    output proc_pkg::word_t address_imem,
    input  proc_pkg::word_t q_imem,
    output proc_pkg::word_t fd_instr,
    output proc_pkg::word_t fd_pc,
    output logic            fd_valid
);
    import proc_pkg::*;

    word_t pc;
    word_t pc_next;

    // Redirect has priority over a stall
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + word_t'(1);
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc       <= '0;
            fd_valid <= 1'b0;
        end else begin
            pc <= pc_next;
            if (redirect) begin
                fd_valid <= 1'b0;
            end else if (!stall) begin
                fd_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            fd_instr <= q_imem;
            fd_pc    <= pc;
        end
    end

    assign address_imem = pc;

endmodule

//--- source/hazard_unit.sv
`timescale 1ns/100ps
// Hazard detection
// Load-use stall and selection of the forwarding source for each execute operand

module hazard_unit (
    dx_if.sink                  dx,
    result_if.sink              res,
    input  proc_pkg::reg_addr_t fd_reg_a,
    input  proc_pkg::reg_addr_t fd_reg_b,
    input  logic                uses_a,
    input  logic                uses_b,
    output logic                stall,
    output proc_pkg::fwd_sel_t  fwd_a,
    output proc_pkg::fwd_sel_t  fwd_b
);
    import proc_pkg::*;

    logic load_in_dx;

    // Nearest producer wins and r0 never matches
    function automatic fwd_sel_t pick_source(reg_addr_t src, reg_addr_t xm_dest,
                                             logic xm_is_load, reg_addr_t mw_dest);
        fwd_sel_t sel;
        sel = FWD_NONE;
        if (src != '0 && src == xm_dest && !xm_is_load) begin
            sel = FWD_XM;
        end else if (src != '0 && src == mw_dest) begin
            sel = FWD_MW;
        end
        return sel;
    endfunction

    assign fwd_a = pick_source(dx.reg_a, res.xm_dest, res.xm_is_load, res.mw_dest);
    assign fwd_b = pick_source(dx.reg_b, res.xm_dest, res.xm_is_load, res.mw_dest);

    // Load data is only ready in MW so a dependent instruction waits one cycle
    assign load_in_dx = dx.valid && (dx.op == OP_LW) && (dx.dest != '0);
    assign stall = load_in_dx && ((uses_a && fd_reg_a == dx.dest) ||
                                  (uses_b && fd_reg_b == dx.dest));

endmodule

//--- source/mem_wb_unit.sv
`timescale 1ns/100ps
// Memory and writeback stages
// XM drives the data memory, MW holds the value for the register file write

module mem_wb_unit (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                ex_valid,
    input  proc_pkg::opcode_t   ex_op,
    input  proc_pkg::reg_addr_t ex_dest,
    input  proc_pkg::word_t     ex_result,
    input  proc_pkg::word_t     ex_store_data,
    output proc_pkg::word_t     address_dmem,
    output proc_pkg::word_t     data,
    output logic                wren,
    input  proc_pkg::word_t     q_dmem,
    result_if.stage             res,
    output logic                ctrl_writeEnable,
    output proc_pkg::reg_addr_t ctrl_writeReg,
    output proc_pkg::word_t     data_writeReg
);
    import proc_pkg::*;

    logic      xm_valid;
    opcode_t   xm_op;
    reg_addr_t xm_dest;
    word_t     xm_result;
    word_t     xm_store_data;
    logic      xm_is_load;
    reg_addr_t mw_dest;
    word_t     mw_result;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            xm_valid <= 1'b0;
            xm_op    <= OP_NOP;
            xm_dest  <= '0;
            mw_dest  <= '0;
        end else begin
            xm_valid <= ex_valid;
            xm_op    <= ex_op;
            xm_dest  <= ex_valid ? ex_dest : '0;
            mw_dest  <= xm_dest;
        end
    end

    always_ff @(posedge clock) begin
        xm_result     <= ex_result;
        xm_store_data <= ex_store_data;
        mw_result     <= xm_is_load ? q_dmem : xm_result;
    end

    assign xm_is_load   = xm_valid && (xm_op == OP_LW);
    assign address_dmem = xm_result;
    assign data         = xm_store_data;
    assign wren         = xm_valid && (xm_op == OP_SW);

    // Forwarding taps
    assign res.xm_dest    = xm_dest;
    assign res.xm_result  = xm_result;
    assign res.xm_is_load = xm_is_load;
    assign res.mw_dest    = mw_dest;
    assign res.mw_result  = mw_result;

    // A zero destination means nothing to write
    assign ctrl_writeEnable = (mw_dest != '0);
    assign ctrl_writeReg    = mw_dest;
    assign data_writeReg    = mw_result;

endmodule

//--- source/pipe_if.sv
`timescale 1ns/100ps
// Pipeline bundles passed between stages
// dx_if is the DX register content, result_if the XM and MW results used for forwarding

interface dx_if;
    import proc_pkg::*;

    logic      valid;
    opcode_t   op;
    alu_op_t   alu_op;
    shamt_t    shamt;
    reg_addr_t reg_a;
    reg_addr_t reg_b;
    reg_addr_t dest;
    word_t     a_value;
    word_t     b_value;
    word_t     imm;
    word_t     target;
    word_t     pc;

    modport stage (output valid, op, alu_op, shamt, reg_a, reg_b, dest,
                   output a_value, b_value, imm, target, pc);
    modport sink (input valid, op, alu_op, shamt, reg_a, reg_b, dest,
                  input a_value, b_value, imm, target, pc);
endinterface

interface result_if;
    import proc_pkg::*;

    reg_addr_t xm_dest;
    word_t     xm_result;
    logic      xm_is_load;
    reg_addr_t mw_dest;
    word_t     mw_result;

    modport stage (output xm_dest, xm_result, xm_is_load, mw_dest, mw_result);
    modport sink (input xm_dest, xm_result, xm_is_load, mw_dest, mw_result);
endinterface

//--- source/proc_pkg.sv
// Shared definitions for the five-stage pipelined processor
// Word and register widths, instruction fields and control encodings

package proc_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Return address register for jal
    localparam reg_addr_t LINK_REG = reg_addr_t'(31);

    // Instruction field positions
    localparam int OPC_HI   = 31;
    localparam int OPC_LO   = 27;
    localparam int RD_HI    = 26;
    localparam int RD_LO    = 22;
    localparam int RS_HI    = 21;
    localparam int RS_LO    = 17;
    localparam int RT_HI    = 16;
    localparam int RT_LO    = 12;
    localparam int SHAMT_HI = 11;
    localparam int SHAMT_LO = 7;
    localparam int ALUOP_HI = 6;
    localparam int ALUOP_LO = 2;
    localparam int IMM_W    = 17;   // sign-extended
    localparam int TARGET_W = 27;   // zero-extended

    typedef logic [SHAMT_HI-SHAMT_LO:0] shamt_t;

    typedef enum logic [OPC_HI-OPC_LO:0] {
        OP_RTYPE = 5'd0,
        OP_J     = 5'd1,
        OP_BNE   = 5'd2,
        OP_JAL   = 5'd3,
        OP_JR    = 5'd4,
        OP_ADDI  = 5'd5,
        OP_BLT   = 5'd6,
        OP_SW    = 5'd7,
        OP_LW    = 5'd8,
        OP_NOP   = 5'd31
    } opcode_t;

    typedef enum logic [ALUOP_HI-ALUOP_LO:0] {
        ALU_ADD = 5'd0,
        ALU_SUB = 5'd1,
        ALU_AND = 5'd2,
        ALU_OR  = 5'd3,
        ALU_SLL = 5'd4,
        ALU_SRA = 5'd5
    } alu_op_t;

    // Source of an execute operand
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_XM,
        FWD_MW
    } fwd_sel_t;

endpackage

//--- source/processor.sv
`timescale 1ns/100ps
// Five-stage pipelined processor top level
// Instruction memory, data memory and register file are outside and reached through ports

module processor (
    input  logic                clock,
    input  logic                arst_n,
    output proc_pkg::word_t     address_imem,
    input  proc_pkg::word_t     q_imem,
    output proc_pkg::word_t     address_dmem,
    output proc_pkg::word_t     data,
    output logic                wren,
    input  proc_pkg::word_t     q_dmem,
    output logic                ctrl_writeEnable,
    output proc_pkg::reg_addr_t ctrl_writeReg,
    output proc_pkg::reg_addr_t ctrl_readRegA,
    output proc_pkg::reg_addr_t ctrl_readRegB,
    output proc_pkg::word_t     data_writeReg,
    input  proc_pkg::word_t     data_readRegA,
    input  proc_pkg::word_t     data_readRegB
);
    import proc_pkg::*;

    word_t     fd_instr;
    word_t     fd_pc;
    logic      fd_valid;
    logic      stall;
    logic      redirect;
    word_t     redirect_pc;
    logic      uses_a;
    logic      uses_b;
    fwd_sel_t  fwd_a;
    fwd_sel_t  fwd_b;
    logic      ex_valid;
    opcode_t   ex_op;
    reg_addr_t ex_dest;
    word_t     ex_result;
    word_t     ex_store_data;

    // Stage bundles
    dx_if     dx ();
    result_if res ();

    fetch_unit u_fetch (.*);

    decode_unit u_decode (.*);

    hazard_unit u_hazard (
        .fd_reg_a (ctrl_readRegA),
        .fd_reg_b (ctrl_readRegB),
        .*
    );

    execute_unit u_execute (.*);

    mem_wb_unit u_mem_wb (.*);

endmodule
